//--- logic/uart_baud_gen.sv
// --------------------------------------------------
// UART tick generator
// Free-running divider giving one clock wide pulse
// at sixteen times the bit rate
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen
	import uart_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	logic [TICK_CNT_W-1:0] div_cnt;
	logic                  wrap;

	// Last count of the divider period
	assign wrap = (div_cnt == TICK_CNT_W'(BAUD_DIV - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			if (wrap) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			// Registered, so first pulse lands BAUD_DIV clocks out of reset
			tick <= wrap;
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// Tick is a single clock pulse
	a_tick_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		tick |=> !tick
	);

endmodule

`default_nettype wire

//--- logic/uart_core.sv
// --------------------------------------------------
// UART core top level
// 8N1 receiver and transmitter at a fixed rate with
// req/ack byte exchange on the host side
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_core
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// Serial pins
	input  logic       rx,
	output logic       tx,
	// Receive handshake
	output logic       rx_req,
	output rx_word_t   rx_word,
	input  logic       rx_ack,
	// Transmit handshake
	input  logic       tx_req,
	input  logic [7:0] tx_data,
	output logic       tx_ack
);

	logic     tick;
	rx_word_t word;
	logic     word_valid;

	uart_baud_gen i_baud_gen (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	uart_rx i_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.tick       (tick),
		.rx         (rx),
		.word       (word),
		.word_valid (word_valid)
	);

	uart_rx_port i_rx_port (
		.clk        (clk),
		.rst_n      (rst_n),
		.word       (word),
		.word_valid (word_valid),
		.rx_req     (rx_req),
		.rx_word    (rx_word),
		.rx_ack     (rx_ack)
	);

	uart_tx i_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tick    (tick),
		.tx_req  (tx_req),
		.tx_data (tx_data),
		.tx_ack  (tx_ack),
		.tx      (tx)
	);

endmodule

`default_nettype wire

//--- logic/uart_pkg.sv
// --------------------------------------------------
// UART shared definitions
// Fixed rate constants, FSM state types and the
// received word format used across the core
// --------------------------------------------------
`default_nettype none

package uart_pkg;

	// --------------------------------------------------
	// Rate
	// --------------------------------------------------
	localparam int CLK_FREQ   = 50_000_000;
	localparam int BAUD_RATE  = 312_500;
	localparam int OVERSAMPLE = 16;
	// Clocks between oversample ticks
	localparam int BAUD_DIV   = CLK_FREQ / (BAUD_RATE * OVERSAMPLE);
	localparam int TICK_CNT_W = 4;

	// --------------------------------------------------
	// FSM states
	// --------------------------------------------------
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_WAIT_IDLE
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// Received byte with its status flags
	typedef struct packed {
		logic [7:0] data;
		logic       frame_err;  // stop bit sampled low
		logic       overrun;    // at least one word lost before this one
	} rx_word_t;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
// --------------------------------------------------
// UART receiver
// Oversamples rx at 16x, validates the start bit at
// mid-bit, shifts data in LSB first and checks stop
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import uart_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     tick,
	input  logic     rx,
	output rx_word_t word,
	output logic     word_valid
);

	rx_state_t                       state;
	logic                            rx_meta;
	logic                            rx_sync;
	logic [$clog2(OVERSAMPLE)-1:0]   tick_cnt;
	logic [2:0]                      bit_cnt;
	logic [7:0]                      shift_reg;
	logic                            frame_err;
	logic                            mid_bit;
	logic                            bit_end;

	// --------------------------------------------------
	// Input synchronizer
	// --------------------------------------------------
	// Idle line is high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Half a bit after the falling edge, then whole bits
	assign mid_bit = (int'(tick_cnt) == OVERSAMPLE / 2 - 1);
	assign bit_end = (int'(tick_cnt) == OVERSAMPLE - 1);

	// --------------------------------------------------
	// Receive FSM
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= RX_IDLE;
			tick_cnt   <= '0;
			bit_cnt    <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (tick) begin
				case (state)
					RX_IDLE: begin
						if (!rx_sync) begin
							state    <= RX_START;
							tick_cnt <= '0;
						end
					end
					RX_START: begin
						if (mid_bit) begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							// High at mid start bit means a glitch
							state    <= rx_sync ? RX_IDLE : RX_DATA;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_DATA: begin
						if (bit_end) begin
							tick_cnt <= '0;
							bit_cnt  <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7) begin
								state <= RX_STOP;
							end
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_STOP: begin
						if (bit_end) begin
							tick_cnt   <= '0;
							word_valid <= 1'b1;
							state      <= rx_sync ? RX_IDLE : RX_WAIT_IDLE;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_WAIT_IDLE: begin
						// Bad stop bit, hold off until the line is back high
						if (rx_sync) begin
							state <= RX_IDLE;
						end
					end
					default: begin
						state <= RX_IDLE;
					end
				endcase
			end
		end
	end

	// Data and stop samples
	always_ff @(posedge clk) begin
		if (tick && bit_end && state == RX_DATA) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
		if (tick && bit_end && state == RX_STOP) begin
			frame_err <= !rx_sync;
		end
	end

	assign word = '{data: shift_reg, frame_err: frame_err, overrun: 1'b0};

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_valid_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		word_valid |=> !word_valid
	);

endmodule

`default_nettype wire

//--- logic/uart_rx_port.sv
// --------------------------------------------------
// UART receive port
// Holds one received word, delivers it to the host
// over req/ack and tracks lost words as overrun
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_rx_port
	import uart_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  rx_word_t word,
	input  logic     word_valid,
	output logic     rx_req,
	output rx_word_t rx_word,
	input  logic     rx_ack
);

	logic held;
	logic ovr_sticky;
	logic capture;

	// Holding register busy until the handshake completes
	assign capture = word_valid && !held;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held       <= 1'b0;
			rx_req     <= 1'b0;
			ovr_sticky <= 1'b0;
		end else begin
			if (capture) begin
				held       <= 1'b1;
				rx_req     <= 1'b1;
				// Reported with this word
				ovr_sticky <= 1'b0;
			end else begin
				if (word_valid) begin
					// No room, drop it
					ovr_sticky <= 1'b1;
				end
				if (rx_req && rx_ack) begin
					rx_req <= 1'b0;
				end else if (held && !rx_req && !rx_ack) begin
					held <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			rx_word <= '{data: word.data, frame_err: word.frame_err, overrun: ovr_sticky};
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_word_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		rx_req |=> !rx_req || $stable(rx_word)
	);

	a_req_after_ack_low: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(rx_req) |-> !rx_ack
	);

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
// --------------------------------------------------
// UART transmitter
// Takes a byte over a four-phase handshake and sends
// start, eight data bits LSB first and stop
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tick,
	input  logic       tx_req,
	input  logic [7:0] tx_data,
	output logic       tx_ack,
	output logic       tx
);

	tx_state_t                     state;
	logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
	logic [2:0]                    bit_cnt;
	logic [7:0]                    shift_reg;
	logic                          loaded;
	logic                          accept;
	logic                          bit_end;

	// Only take a byte with the line idle and nothing queued
	assign accept  = tx_req && !tx_ack && !loaded && (state == TX_IDLE);
	// Bit boundaries follow a free-running 16-tick phase
	assign bit_end = tick && (int'(tick_cnt) == OVERSAMPLE - 1);

	// --------------------------------------------------
	// Handshake and transmit FSM
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			loaded   <= 1'b0;
			tx_ack   <= 1'b0;
			tx       <= 1'b1;
		end else begin
			if (tick) begin
				tick_cnt <= tick_cnt + 1'b1;
			end

			if (accept) begin
				tx_ack <= 1'b1;
				loaded <= 1'b1;
			end else if (tx_ack && !tx_req) begin
				tx_ack <= 1'b0;
			end

			if (bit_end) begin
				case (state)
					TX_IDLE: begin
						if (loaded) begin
							loaded <= 1'b0;
							tx     <= 1'b0;
							state  <= TX_START;
						end
					end
					TX_START: begin
						tx      <= shift_reg[0];
						bit_cnt <= '0;
						state   <= TX_DATA;
					end
					TX_DATA: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							tx    <= 1'b1;
							state <= TX_STOP;
						end else begin
							tx <= shift_reg[0];
						end
					end
					TX_STOP: begin
						state <= TX_IDLE;
					end
					default: begin
						state <= TX_IDLE;
					end
				endcase
			end
		end
	end

	// Byte shifter
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= tx_data;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// A new byte is acknowledged only with the line idle
	a_ack_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(tx_ack) |-> (state == TX_IDLE) && tx
	);

endmodule

`default_nettype wire

//--- sim/tb_uart_core.sv
// --------------------------------------------------
// UART core testbench
// Serial driver and monitor, host handshake model
// and assertion based checking of the core
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_uart_core
	import uart_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int BIT_CLKS   = BAUD_DIV * OVERSAMPLE;
	localparam int FRAME_CLKS = BIT_CLKS * 10;
	localparam int NUM_TX     = 10;
	// Received frames plus transmitted frames
	localparam int NUM_FRAMES = 27 + NUM_TX;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       rx;
	logic       tx;
	logic       rx_req;
	rx_word_t   rx_word;
	logic       rx_ack = 1'b0;
	logic       tx_req;
	logic [7:0] tx_data;
	logic       tx_ack;

	integer     seed = 12;
	int         cycle_cnt = 0;
	logic       reset_window;
	rx_word_t   exp_word = '0;
	int         exp_count = 0;
	int         rx_count = 0;
	logic       rx_req_q = 1'b0;
	logic       host_enable = 1'b1;
	int         ack_delay;
	logic [7:0] tx_expected[$];
	logic [7:0] mon_byte;
	logic [9:0] mon_frame;
	logic       mon_check = 1'b0;
	logic       mon_exp = 1'b1;
	logic       mon_busy = 1'b0;
	int         tx_frames_done = 0;

	uart_core i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.tx      (tx),
		.rx_req  (rx_req),
		.rx_word (rx_word),
		.rx_ack  (rx_ack),
		.tx_req  (tx_req),
		.tx_data (tx_data),
		.tx_ack  (tx_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------------------------------------
	// Failure reporting
	// --------------------------------------------------
	task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("[ERROR] %s expected 0x%0h actual 0x%0h", sig, exp_val, act_val);
		$display("RESULT: FAIL");
		$fatal(1, "check failed on %s", sig);
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		$display("RESULT: FAIL");
		$fatal(1, "%s", what);
	endtask

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// Edges two to six see reset values and the clock after release
	assign reset_window = (cycle_cnt >= 1) && (cycle_cnt <= 5);

	a_reset_tx: assert property (@(posedge clk) reset_window |-> tx === 1'b1)
		else report_mismatch("tx", 32'h1, $sampled(tx));
	a_reset_rx_req: assert property (@(posedge clk) reset_window |-> rx_req === 1'b0)
		else report_mismatch("rx_req", 32'h0, $sampled(rx_req));
	a_reset_tx_ack: assert property (@(posedge clk) reset_window |-> tx_ack === 1'b0)
		else report_mismatch("tx_ack", 32'h0, $sampled(tx_ack));

	a_rx_word: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(rx_req) |-> rx_word == exp_word
	) else report_mismatch("rx_word", $sampled(exp_word), $sampled(rx_word));

	a_tx_bit: assert property (
		@(posedge clk) disable iff (!rst_n)
		mon_check |-> tx == mon_exp
	) else report_mismatch("tx", $sampled(mon_exp), $sampled(tx));

	a_tx_ack_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(tx_ack) |-> !mon_busy
	) else report_problem("tx_ack rose while a frame was still on the tx line");

	// Cycle counter and rx_req rising edges
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		rx_req_q  <= rx_req;
		if (rst_n && rx_req && !rx_req_q) begin
			rx_count <= rx_count + 1;
		end
	end

	// --------------------------------------------------
	// Host model answering rx_req after 1 to 8 clocks
	// --------------------------------------------------
	always begin
		@(posedge clk);
		if (host_enable && rst_n && rx_req && !rx_ack) begin
			ack_delay = 1 + ($unsigned($random(seed)) % 8);
			repeat (ack_delay - 1) @(posedge clk);
			rx_ack <= 1'b1;
			do begin
				@(posedge clk);
			end while (rx_req);
			rx_ack <= 1'b0;
		end
	end

	// --------------------------------------------------
	// Serial monitor on tx
	// --------------------------------------------------
	task automatic check_point();
		mon_check <= 1'b1;
		@(posedge clk);
		mon_check <= 1'b0;
	endtask

	// Each bit is checked near its start, middle and end
	initial begin
		forever begin
			@(posedge clk);
			if (rst_n && tx === 1'b0) begin
				if (tx_expected.size() == 0) begin
					report_problem("frame on tx without a requested byte");
				end else begin
					mon_byte = tx_expected.pop_front();
					mon_frame = {1'b1, mon_byte, 1'b0};
					mon_busy <= 1'b1;
					for (int i = 0; i < 10; i++) begin
						mon_exp <= mon_frame[i];
						check_point();
						repeat (BIT_CLKS / 2 - 3) @(posedge clk);
						check_point();
						repeat (BIT_CLKS / 2 - 3) @(posedge clk);
						check_point();
						repeat (3) @(posedge clk);
					end
					mon_busy       <= 1'b0;
					tx_frames_done <= tx_frames_done + 1;
				end
			end
		end
	end

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
		rx <= 1'b0;
		repeat (BIT_CLKS) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			rx <= data[i];
			repeat (BIT_CLKS) @(posedge clk);
		end
		rx <= stop_bit;
		repeat (BIT_CLKS) @(posedge clk);
		rx <= 1'b1;
	endtask

	task automatic drive_glitch(input int len);
		rx <= 1'b0;
		repeat (len) @(posedge clk);
		rx <= 1'b1;
	endtask

	task automatic receive_byte(input logic [7:0] data, input logic stop_bit,
			input logic ovr);
		exp_word  <= '{data: data, frame_err: !stop_bit, overrun: ovr};
		exp_count = exp_count + 1;
		drive_frame(data, stop_bit);
		// Word must be out before the next frame starts
		assert (rx_count == exp_count)
			else report_mismatch("rx_count", exp_count, rx_count);
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	task automatic send_tx_byte(input logic [7:0] data);
		tx_expected.push_back(data);
		tx_data <= data;
		tx_req  <= 1'b1;
		do begin
			@(posedge clk);
		end while (!tx_ack);
		tx_req <= 1'b0;
		do begin
			@(posedge clk);
		end while (tx_ack);
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		rx      <= 1'b1;
		rst_n   <= 1'b0;
		tx_req  <= 1'b0;
		tx_data <= '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (BIT_CLKS) @(posedge clk);

		repeat (20) begin
			receive_byte(random_byte(), 1'b1, 1'b0);
		end

		// Low stop bit followed by a good frame
		receive_byte(random_byte(), 1'b0, 1'b0);
		receive_byte(random_byte(), 1'b1, 1'b0);

		// Glitch of a quarter bit
		drive_glitch(40);
		// A wrongly accepted start would deliver a word within one frame
		repeat (FRAME_CLKS) @(posedge clk);
		assert (rx_count == exp_count)
			else report_mismatch("rx_count", exp_count, rx_count);
		receive_byte(random_byte(), 1'b1, 1'b0);

		// Host stalls while two more words arrive and get dropped
		host_enable <= 1'b0;
		receive_byte(random_byte(), 1'b1, 1'b0);
		repeat (2) begin
			drive_frame(random_byte(), 1'b1);
			repeat (BIT_CLKS) @(posedge clk);
		end
		assert (rx_count == exp_count)
			else report_mismatch("rx_count", exp_count, rx_count);
		host_enable <= 1'b1;
		do begin
			@(posedge clk);
		end while (rx_req || rx_ack);
		receive_byte(random_byte(), 1'b1, 1'b1);

		repeat (NUM_TX) begin
			send_tx_byte(random_byte());
		end
		while (tx_frames_done != NUM_TX) begin
			@(posedge clk);
		end

		$display("RESULT: PASS");
		$finish;
	end

	// Watchdog
	initial begin
		#((NUM_FRAMES + 10) * FRAME_CLKS * CLK_PERIOD);
		report_problem("timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

//--- src.f
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_rx_port.sv
logic/uart_tx.sv
logic/uart_core.sv
sim/tb_uart_core.sv
